// ==== filelist.f ====
i2c_bus_pkg.sv
slave_map_pkg.sv
i2c_line_monitor.sv
i2c_slave_rx.sv
slave_reg_bank.sv
i2c_master_tx.sv
i2c_link_top.sv
i2c_link_chk.sv
tb_i2c_link.sv

// ==== i2c_bus_pkg.sv ====
`default_nettype none

////////////////////////////////////////
// i2c bus protocol constants
////////////////////////////////////////

package i2c_bus_pkg;

    // clk cycles per scl half period
    localparam int scl_half_cycles = 8;

    // fixed address of the register slave
    localparam logic [6:0] slave_address = 7'h55;

    // data bits in one bus byte
    localparam int bits_per_byte = 8;

    // counts 0..8, bit 8 is the acknowledge slot
    localparam int bit_index_width = 4;

endpackage

`default_nettype wire

// ==== i2c_line_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_line_monitor (
    input  logic clk,
    input  logic reset,
    input  logic scl,
    input  logic sda,
    output logic scl_s,
    output logic sda_s,
    output logic scl_rise,
    output logic scl_fall,
    output logic start_seen,
    output logic stop_seen
);

    logic scl_meta;
    logic scl_sync;
    logic scl_last;
    logic sda_meta;
    logic sda_sync;
    logic sda_last;
    logic scl_steady_high;

    // two-stage synchronizers plus one history sample
    // idle bus level is high on both lines
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            scl_meta <= 1'b1;
            scl_sync <= 1'b1;
            scl_last <= 1'b1;
            sda_meta <= 1'b1;
            sda_sync <= 1'b1;
            sda_last <= 1'b1;
        end else begin
            scl_meta <= scl;
            scl_sync <= scl_meta;
            scl_last <= scl_sync;
            sda_meta <= sda;
            sda_sync <= sda_meta;
            sda_last <= sda_sync;
        end
    end

    assign scl_s = scl_sync;
    assign sda_s = sda_sync;

    assign scl_rise = scl_sync & ~scl_last;
    assign scl_fall = ~scl_sync & scl_last;

    // scl high in both samples, so an sda edge that lands with an scl edge is no start or stop
    assign scl_steady_high = scl_sync & scl_last;

    assign start_seen = scl_steady_high & sda_last & ~sda_sync;
    assign stop_seen  = scl_steady_high & ~sda_last & sda_sync;

endmodule

`default_nettype wire

// ==== i2c_link_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_link_chk (
    input logic clk,
    input logic reset,
    input logic scl_s,
    input logic slave_sda_low,
    input logic byte_valid,
    input logic [slave_map_pkg::slave_state_width-1:0] slave_state
);

    import slave_map_pkg::*;

    logic in_ack;

    assign in_ack = (slave_state == state_address_ack) || (slave_state == state_data_ack);

    // slave owns sda only in the ninth clock, already pulled before scl rises
    ack_only_in_ack_slot: assert property (
        @(posedge clk) disable iff (reset)
        (slave_sda_low && scl_s) |-> in_ack && $past(slave_sda_low)
    ) else $error("slave pulled sda low with scl high outside an acknowledge state");

    byte_valid_single: assert property (
        @(posedge clk) disable iff (reset)
        byte_valid |=> !byte_valid
    ) else $error("byte_valid was high in two consecutive cycles");

    state_one_hot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot(slave_state)
    ) else $error("slave state is not one-hot");

endmodule

`default_nettype wire

// ==== i2c_link_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_link_top (
    input  logic clk,
    input  logic reset,
    input  logic wr_start,
    input  logic [6:0] wr_addr,
    input  logic [2:0] wr_len,
    input  logic [7:0] tx_byte,
    input  logic response_strobe,
    output logic byte_taken,
    output logic busy,
    output logic done,
    output logic nack_error,
    output logic [7:0] reg0,
    output logic [7:0] reg1,
    output logic [7:0] reg2,
    output logic [7:0] reg3,
    output logic [7:0] reg4,
    output logic go_flag,
    output logic [slave_map_pkg::slave_state_width-1:0] slave_state
);

    logic scl;
    logic sda_bus;
    logic master_sda_low;
    logic slave_sda_low;
    logic scl_s;
    logic sda_s;
    logic scl_rise;
    logic scl_fall;
    logic start_seen;
    logic stop_seen;
    logic byte_valid;
    logic frame_begin;
    logic frame_end;
    logic [7:0] rx_byte;

    // open-drain bus as a wired-AND
    assign sda_bus = ~(master_sda_low | slave_sda_low);

    i2c_master_tx u_master (
        .clk            (clk),
        .reset          (reset),
        .wr_start       (wr_start),
        .wr_addr        (wr_addr),
        .wr_len         (wr_len),
        .tx_byte        (tx_byte),
        .sda_in         (sda_bus),
        .scl            (scl),
        .master_sda_low (master_sda_low),
        .byte_taken     (byte_taken),
        .busy           (busy),
        .done           (done),
        .nack_error     (nack_error)
    );

    i2c_line_monitor u_monitor (
        .clk        (clk),
        .reset      (reset),
        .scl        (scl),
        .sda        (sda_bus),
        .scl_s      (scl_s),
        .sda_s      (sda_s),
        .scl_rise   (scl_rise),
        .scl_fall   (scl_fall),
        .start_seen (start_seen),
        .stop_seen  (stop_seen)
    );

    i2c_slave_rx u_slave (
        .clk           (clk),
        .reset         (reset),
        .scl_s         (scl_s),
        .sda_s         (sda_s),
        .scl_rise      (scl_rise),
        .scl_fall      (scl_fall),
        .start_seen    (start_seen),
        .stop_seen     (stop_seen),
        .slave_sda_low (slave_sda_low),
        .byte_valid    (byte_valid),
        .frame_begin   (frame_begin),
        .frame_end     (frame_end),
        .rx_byte       (rx_byte),
        .slave_state   (slave_state)
    );

    slave_reg_bank u_bank (
        .clk             (clk),
        .reset           (reset),
        .byte_valid      (byte_valid),
        .frame_begin     (frame_begin),
        .frame_end       (frame_end),
        .rx_byte         (rx_byte),
        .response_strobe (response_strobe),
        .reg0            (reg0),
        .reg1            (reg1),
        .reg2            (reg2),
        .reg3            (reg3),
        .reg4            (reg4),
        .go_flag         (go_flag)
    );

endmodule

`default_nettype wire

// ==== i2c_master_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_master_tx (
    input  logic clk,
    input  logic reset,
    input  logic wr_start,
    input  logic [6:0] wr_addr,
    input  logic [2:0] wr_len,
    input  logic [7:0] tx_byte,
    input  logic sda_in,
    output logic scl,
    output logic master_sda_low,
    output logic byte_taken,
    output logic busy,
    output logic done,
    output logic nack_error
);

    import i2c_bus_pkg::*;

    localparam int div_width = $clog2(scl_half_cycles);

    typedef enum logic [2:0] {
        m_idle,
        m_start,
        m_low,
        m_high,
        m_stop_low,
        m_stop_high,
        m_stop_end
    } m_state_e;

    m_state_e state;
    logic [div_width-1:0] div_cnt;
    logic half_tick;
    logic [bits_per_byte-1:0] shift_reg;
    logic [bit_index_width-1:0] bit_cnt;
    logic [2:0] bytes_left;
    logic ack_bit;
    logic last_data_bit;

    assign half_tick     = (div_cnt == div_width'(scl_half_cycles - 1));
    assign ack_bit       = (bit_cnt == bit_index_width'(bits_per_byte));
    assign last_data_bit = (bit_cnt == bit_index_width'(bits_per_byte - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state          <= m_idle;
            div_cnt        <= '0;
            shift_reg      <= '0;
            bit_cnt        <= '0;
            bytes_left     <= '0;
            scl            <= 1'b1;
            master_sda_low <= 1'b0;
            byte_taken     <= 1'b0;
            busy           <= 1'b0;
            done           <= 1'b0;
            nack_error     <= 1'b0;
        end else begin
            byte_taken <= 1'b0;
            done       <= 1'b0;

            // half period divider
            if (state == m_idle || half_tick) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end

            case (state)
                m_idle: begin
                    if (wr_start) begin
                        shift_reg      <= {wr_addr, 1'b0};
                        bytes_left     <= wr_len;
                        bit_cnt        <= '0;
                        nack_error     <= 1'b0;
                        busy           <= 1'b1;
                        // sda falls with scl high
                        master_sda_low <= 1'b1;
                        state          <= m_start;
                    end
                end
                m_start: begin
                    if (half_tick) begin
                        scl            <= 1'b0;
                        master_sda_low <= ~shift_reg[bits_per_byte-1];
                        state          <= m_low;
                    end
                end
                m_low: begin
                    if (half_tick) begin
                        scl   <= 1'b1;
                        state <= m_high;
                        // ack sampled on the scl rise
                        if (ack_bit) begin
                            nack_error <= nack_error | sda_in;
                        end
                    end
                end
                m_high: begin
                    if (half_tick) begin
                        scl <= 1'b0;
                        if (!ack_bit) begin
                            bit_cnt        <= bit_cnt + 1'b1;
                            shift_reg      <= {shift_reg[bits_per_byte-2:0], 1'b0};
                            master_sda_low <= last_data_bit ? 1'b0
                                                            : ~shift_reg[bits_per_byte-2];
                            state          <= m_low;
                        end else if (nack_error || bytes_left == 3'd0) begin
                            master_sda_low <= 1'b1;
                            state          <= m_stop_low;
                        end else begin
                            shift_reg      <= tx_byte;
                            master_sda_low <= ~tx_byte[bits_per_byte-1];
                            byte_taken     <= 1'b1;
                            bytes_left     <= bytes_left - 1'b1;
                            bit_cnt        <= '0;
                            state          <= m_low;
                        end
                    end
                end
                m_stop_low: begin
                    if (half_tick) begin
                        scl   <= 1'b1;
                        state <= m_stop_high;
                    end
                end
                // sda rises with scl high
                m_stop_high: begin
                    if (half_tick) begin
                        master_sda_low <= 1'b0;
                        state          <= m_stop_end;
                    end
                end
                m_stop_end: begin
                    if (half_tick) begin
                        busy  <= 1'b0;
                        done  <= 1'b1;
                        state <= m_idle;
                    end
                end
                default: begin
                    state <= m_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== i2c_slave_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_rx (
    input  logic clk,
    input  logic reset,
    input  logic scl_s,
    input  logic sda_s,
    input  logic scl_rise,
    input  logic scl_fall,
    input  logic start_seen,
    input  logic stop_seen,
    output logic slave_sda_low,
    output logic byte_valid,
    output logic frame_begin,
    output logic frame_end,
    output logic [7:0] rx_byte,
    output logic [slave_map_pkg::slave_state_width-1:0] slave_state
);

    import i2c_bus_pkg::*;
    import slave_map_pkg::*;

    logic [slave_state_width-1:0] state;
    logic [bits_per_byte-1:0] shift_reg;
    logic [bit_index_width-1:0] bit_cnt;
    logic last_bit;
    logic addr_match;
    logic in_frame;

    assign last_bit = (bit_cnt == bit_index_width'(bits_per_byte - 1));

    // write to our address only, reads get no acknowledge
    assign addr_match = (shift_reg[7:1] == slave_address) && !shift_reg[0];

    // address already accepted
    assign in_frame = (state == state_address_ack) || (state == state_data)
                   || (state == state_data_ack);

    assign slave_state = state;

    ////////////////////////////////////////
    // bit capture
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (scl_rise) begin
            shift_reg <= {shift_reg[bits_per_byte-2:0], sda_s};
        end
        if (scl_fall && last_bit && state == state_data) begin
            rx_byte <= shift_reg;
        end
    end

    ////////////////////////////////////////
    // protocol engine
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= state_idle;
            bit_cnt       <= '0;
            slave_sda_low <= 1'b0;
            byte_valid    <= 1'b0;
            frame_begin   <= 1'b0;
            frame_end     <= 1'b0;
        end else begin
            byte_valid  <= 1'b0;
            frame_begin <= 1'b0;
            frame_end   <= 1'b0;
            if (start_seen) begin
                state         <= state_start;
                slave_sda_low <= 1'b0;
            end else if (stop_seen) begin
                slave_sda_low <= 1'b0;
                if (in_frame) begin
                    state     <= state_stopped;
                    frame_end <= 1'b1;
                end else begin
                    state <= state_idle;
                end
            end else begin
                case (state)
                    state_idle: begin
                        bit_cnt <= '0;
                    end
                    // scl still high after the start
                    state_start: begin
                        if (scl_fall) begin
                            state   <= state_address;
                            bit_cnt <= '0;
                        end
                    end
                    state_address: begin
                        if (scl_fall) begin
                            if (!last_bit) begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end else if (addr_match) begin
                                state         <= state_address_ack;
                                slave_sda_low <= 1'b1;
                                frame_begin   <= 1'b1;
                            end else begin
                                state <= state_idle;
                            end
                        end
                    end
                    state_data: begin
                        if (scl_fall) begin
                            if (last_bit) begin
                                state         <= state_data_ack;
                                slave_sda_low <= 1'b1;
                                byte_valid    <= 1'b1;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end
                    // release sda once the ninth clock ends
                    state_address_ack, state_data_ack: begin
                        if (scl_fall) begin
                            state         <= state_data;
                            slave_sda_low <= 1'b0;
                            bit_cnt       <= '0;
                        end
                    end
                    state_stopped: begin
                        if (scl_s && sda_s) begin
                            state <= state_idle;
                        end
                    end
                    default: begin
                        state <= state_idle;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module tb_i2c_link \
    -o tb_i2c_link_sim > build.log 2>&1 \
    && ./obj_dir/tb_i2c_link_sim > sim.log 2>&1 \
    || echo "build or simulation did not complete" >> sim.log
cat build.log sim.log
grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "FAIL"; exit 1; }
echo "PASS"

// ==== slave_map_pkg.sv ====
`default_nettype none

package slave_map_pkg;

    // data registers behind the slave
    localparam int reg_count = 5;
    localparam int reg_index_width = 3;

    // one-hot slave engine states
    localparam int slave_state_width = 7;

    localparam logic [slave_state_width-1:0] state_idle        = 7'b000_0001;
    localparam logic [slave_state_width-1:0] state_start       = 7'b000_0010;
    localparam logic [slave_state_width-1:0] state_address     = 7'b000_0100;
    localparam logic [slave_state_width-1:0] state_address_ack = 7'b000_1000;
    localparam logic [slave_state_width-1:0] state_data        = 7'b001_0000;
    localparam logic [slave_state_width-1:0] state_data_ack    = 7'b010_0000;
    localparam logic [slave_state_width-1:0] state_stopped     = 7'b100_0000;

endpackage

`default_nettype wire

// ==== slave_reg_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module slave_reg_bank (
    input  logic clk,
    input  logic reset,
    input  logic byte_valid,
    input  logic frame_begin,
    input  logic frame_end,
    input  logic [7:0] rx_byte,
    input  logic response_strobe,
    output logic [7:0] reg0,
    output logic [7:0] reg1,
    output logic [7:0] reg2,
    output logic [7:0] reg3,
    output logic [7:0] reg4,
    output logic go_flag
);

    import slave_map_pkg::*;

    logic [7:0] regs [reg_count];
    logic [reg_index_width-1:0] wr_ptr;
    logic ptr_full;

    // extra bytes are acked upstream and dropped here
    assign ptr_full = (wr_ptr == reg_index_width'(reg_count));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (frame_begin) begin
            wr_ptr <= '0;
        end else if (byte_valid && !ptr_full) begin
            regs[wr_ptr] <= rx_byte;
            wr_ptr       <= wr_ptr + 1'b1;
        end
    end

    // set wins over the response clear
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            go_flag <= 1'b0;
        end else if (frame_end) begin
            go_flag <= 1'b1;
        end else if (response_strobe) begin
            go_flag <= 1'b0;
        end
    end

    assign reg0 = regs[0];
    assign reg1 = regs[1];
    assign reg2 = regs[2];
    assign reg3 = regs[3];
    assign reg4 = regs[4];

endmodule

`default_nettype wire

// ==== tb_i2c_link.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_link;

    import i2c_bus_pkg::*;
    import slave_map_pkg::*;

    localparam int byte_clks = 9 * 2 * scl_half_cycles;
    // per write the data bytes plus three for address, start and stop
    localparam int test_byte_times = (5 + 3) + (3 + 3) + (7 + 3) + (2 + 3);
    localparam int margin_byte_times = 10;

    logic clk = 1'b0;
    logic reset;
    logic wr_start;
    logic [6:0] wr_addr;
    logic [2:0] wr_len;
    logic [7:0] tx_byte;
    logic response_strobe;
    logic byte_taken;
    logic busy;
    logic done;
    logic nack_error;
    logic [7:0] reg0;
    logic [7:0] reg1;
    logic [7:0] reg2;
    logic [7:0] reg3;
    logic [7:0] reg4;
    logic go_flag;
    logic [slave_state_width-1:0] slave_state;

    logic [7:0] feed_bytes [8];
    logic [7:0] model_regs [reg_count];
    logic [15:0] lfsr_state;
    int feed_base;
    int total_taken;
    int error_count;
    int check_count;

    i2c_link_top uut (
        .clk             (clk),
        .reset           (reset),
        .wr_start        (wr_start),
        .wr_addr         (wr_addr),
        .wr_len          (wr_len),
        .tx_byte         (tx_byte),
        .response_strobe (response_strobe),
        .byte_taken      (byte_taken),
        .busy            (busy),
        .done            (done),
        .nack_error      (nack_error),
        .reg0            (reg0),
        .reg1            (reg1),
        .reg2            (reg2),
        .reg3            (reg3),
        .reg4            (reg4),
        .go_flag         (go_flag),
        .slave_state     (slave_state)
    );

    bind i2c_slave_rx i2c_link_chk u_chk (
        .clk           (clk),
        .reset         (reset),
        .scl_s         (scl_s),
        .slave_sda_low (slave_sda_low),
        .byte_valid    (byte_valid),
        .slave_state   (slave_state)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////
    // byte feeder
    ////////////////////////////////////////

    // next queued byte after each byte_taken
    assign tx_byte = feed_bytes[3'(total_taken - feed_base)];

    always @(negedge clk) begin
        if (reset) begin
            total_taken <= 0;
        end else if (byte_taken) begin
            total_taken <= total_taken + 1;
        end
    end

    initial begin
        repeat ((test_byte_times + margin_byte_times) * byte_clks) @(posedge clk);
        $display("watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic [15:0] stepped;
        stepped = state >> 1;
        if (state[0]) begin
            stepped = stepped ^ 16'hB400;
        end
        return stepped;
    endfunction

    task automatic random_byte(output logic [7:0] value);
        int i;
        value = 8'h00;
        for (i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[6:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string test_name, input string item,
                               input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("[FAIL] %s %s expected %0h actual %0h", test_name, item, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_regs(input string test_name);
        check_value(test_name, "reg0", 32'(model_regs[0]), 32'(reg0));
        check_value(test_name, "reg1", 32'(model_regs[1]), 32'(reg1));
        check_value(test_name, "reg2", 32'(model_regs[2]), 32'(reg2));
        check_value(test_name, "reg3", 32'(model_regs[3]), 32'(reg3));
        check_value(test_name, "reg4", 32'(model_regs[4]), 32'(reg4));
    endtask

    task automatic wait_for_done(input string test_name, input int limit);
        int cycles;
        cycles = 0;
        while (!done && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("%s: done did not pulse within %0d clock cycles", test_name, limit);
            error_count++;
        end
    endtask

    task automatic pulse_response();
        @(negedge clk);
        response_strobe = 1'b1;
        @(negedge clk);
        response_strobe = 1'b0;
    endtask

    task automatic run_write(input string test_name, input logic [6:0] addr, input int len,
                             output int taken);
        logic [7:0] value;
        int i;
        feed_base = total_taken;
        for (i = 0; i < 8; i++) begin
            feed_bytes[3'(i)] = 8'h00;
        end
        for (i = 0; i < len; i++) begin
            random_byte(value);
            feed_bytes[3'(i)] = value;
        end
        @(negedge clk);
        wr_addr  = addr;
        wr_len   = 3'(len);
        wr_start = 1'b1;
        @(negedge clk);
        wr_start = 1'b0;
        wait_for_done(test_name, (len + 3) * byte_clks);
        taken = total_taken - feed_base;
        // only our address is stored, and only the first reg_count bytes
        if (addr == slave_address) begin
            for (i = 0; i < len && i < reg_count; i++) begin
                model_regs[3'(i)] = feed_bytes[3'(i)];
            end
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic test_reset_state();
        check_value("reset_state", "go_flag", 32'(1'b0), 32'(go_flag));
        check_value("reset_state", "busy", 32'(1'b0), 32'(busy));
        check_value("reset_state", "slave_state", 32'(state_idle), 32'(slave_state));
        check_regs("reset_state");
    endtask

    task automatic test_full_write();
        int taken;
        run_write("full_write", slave_address, 5, taken);
        check_value("full_write", "nack_error", 32'(1'b0), 32'(nack_error));
        check_value("full_write", "byte_taken pulses", 32'(5), 32'(taken));
        check_value("full_write", "go_flag", 32'(1'b1), 32'(go_flag));
        check_regs("full_write");
    endtask

    task automatic test_response_clear();
        pulse_response();
        check_value("response_clear", "go_flag", 32'(1'b0), 32'(go_flag));
        check_regs("response_clear");
    endtask

    task automatic test_wrong_address();
        int taken;
        run_write("wrong_address", slave_address ^ 7'h2A, 3, taken);
        check_value("wrong_address", "nack_error", 32'(1'b1), 32'(nack_error));
        check_value("wrong_address", "byte_taken pulses", 32'(0), 32'(taken));
        check_value("wrong_address", "go_flag", 32'(1'b0), 32'(go_flag));
        check_regs("wrong_address");
    endtask

    task automatic test_overflow_write();
        int taken;
        run_write("overflow_write", slave_address, 7, taken);
        check_value("overflow_write", "nack_error", 32'(1'b0), 32'(nack_error));
        check_value("overflow_write", "byte_taken pulses", 32'(7), 32'(taken));
        check_value("overflow_write", "go_flag", 32'(1'b1), 32'(go_flag));
        check_regs("overflow_write");
    endtask

    task automatic test_short_frame();
        int taken;
        pulse_response();
        check_value("short_frame", "go_flag before", 32'(1'b0), 32'(go_flag));
        run_write("short_frame", slave_address, 2, taken);
        check_value("short_frame", "nack_error", 32'(1'b0), 32'(nack_error));
        check_value("short_frame", "byte_taken pulses", 32'(2), 32'(taken));
        check_value("short_frame", "go_flag", 32'(1'b1), 32'(go_flag));
        check_regs("short_frame");
    endtask

    initial begin
        reset           = 1'b1;
        wr_start        = 1'b0;
        wr_addr         = 7'h00;
        wr_len          = 3'd0;
        response_strobe = 1'b0;
        feed_base       = 0;
        lfsr_state      = 16'd6484;
        error_count     = 0;
        check_count     = 0;
        for (int i = 0; i < 8; i++) begin
            feed_bytes[3'(i)] = 8'h00;
        end
        for (int i = 0; i < reg_count; i++) begin
            model_regs[3'(i)] = 8'h00;
        end
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        test_reset_state();
        test_full_write();
        test_response_clear();
        test_wrong_address();
        test_overflow_write();
        test_short_frame();
        $display("checks run %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
